// File: rtl/armExecPkg.sv
package armExecPkg;

  // ====================
  // Opcodes
  // ====================

  // ALU operations in ARM data-processing encoding
  typedef enum logic [3:0] {
    AND = 4'h0,
    EOR = 4'h1,
    SUB = 4'h2,
    RSB = 4'h3,
    ADD = 4'h4,
    ADC = 4'h5,
    SBC = 4'h6,
    ORR = 4'hC,
    MOV = 4'hD,
    BIC = 4'hE,
    MVN = 4'hF
  } aluOp_e;

  // Shift types for operand B
  typedef enum logic [1:0] {
    LSL = 2'b00,
    LSR = 2'b01,
    ASR = 2'b10,
    ROR = 2'b11
  } shiftOp_e;

  // Which unit's result is written back
  typedef enum logic {
    UNIT_ALU  = 1'b0,
    UNIT_MULT = 1'b1
  } unitSel_e;

  // ====================
  // Flags and tags
  // ====================

  // Bit positions in a 4-bit NZCV vector
  localparam int FlagN = 3;
  localparam int FlagZ = 2;
  localparam int FlagC = 1;
  localparam int FlagV = 0;

  localparam int RegTagWidth = 4;
  // Edges from accepted operation to result strobe
  localparam int ExecLatency = 3;

endpackage

// File: rtl/shiftAlu.sv
module shiftAlu import armExecPkg::*; #(
  parameter int DataWidth = 32
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         opValid,
  input  aluOp_e                       aluOp,
  input  shiftOp_e                     shiftOp,
  input  logic [$clog2(DataWidth)-1:0] shiftAmount,
  input  logic [DataWidth-1:0]         operandA,
  input  logic [DataWidth-1:0]         operandB,
  input  logic [3:0]                   flagsIn,
  output logic [DataWidth-1:0]         aluResult,
  output logic [3:0]                   aluFlags
);

  // Shifter
  logic [DataWidth:0]     lslExt;
  logic [DataWidth:0]     lsrExt;
  logic [DataWidth:0]     asrExt;
  logic [2*DataWidth-1:0] rorExt;
  logic [DataWidth-1:0]   shiftedB;
  logic                   shiftCarry;

  // Stage 1 registers
  logic                 s1Valid;
  aluOp_e               s1AluOp;
  logic [DataWidth-1:0] s1OperandA;
  logic [DataWidth-1:0] s1ShiftedB;
  logic                 s1ShiftCarry;
  logic                 s1CarryIn;
  logic                 s1OverflowIn;

  // ALU
  logic [DataWidth-1:0] addA;
  logic [DataWidth-1:0] addB;
  logic                 addCin;
  logic [DataWidth:0]   addSum;
  logic                 isArith;
  logic [DataWidth-1:0] aluNext;
  logic [3:0]           flagsNext;

  // ====================
  // Stage 1 shifter
  // ====================

  // Extra bit on each side catches the last bit shifted out
  assign lslExt = {1'b0, operandB} << shiftAmount;
  assign lsrExt = {operandB, 1'b0} >> shiftAmount;
  assign asrExt = $signed({operandB, 1'b0}) >>> shiftAmount;
  assign rorExt = {operandB, operandB} >> shiftAmount;

  always_comb begin
    shiftedB   = operandB;
    shiftCarry = flagsIn[FlagC];
    if (shiftAmount != '0) begin
      unique case (shiftOp)
        LSL: begin
          shiftedB   = lslExt[DataWidth-1:0];
          shiftCarry = lslExt[DataWidth];
        end
        LSR: begin
          shiftedB   = lsrExt[DataWidth:1];
          shiftCarry = lsrExt[0];
        end
        ASR: begin
          shiftedB   = asrExt[DataWidth:1];
          shiftCarry = asrExt[0];
        end
        ROR: begin
          shiftedB   = rorExt[DataWidth-1:0];
          shiftCarry = rorExt[DataWidth-1];
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= opValid;
    end
  end

  always_ff @(posedge clk) begin
    if (opValid) begin
      s1AluOp      <= aluOp;
      s1OperandA   <= operandA;
      s1ShiftedB   <= shiftedB;
      s1ShiftCarry <= shiftCarry;
      s1CarryIn    <= flagsIn[FlagC];
      s1OverflowIn <= flagsIn[FlagV];
    end
  end

  // ====================
  // Stage 2 ALU
  // ====================

  // Subtraction is A + ~B + carry, so C means no borrow
  always_comb begin
    addA    = s1OperandA;
    addB    = s1ShiftedB;
    addCin  = 1'b0;
    isArith = 1'b1;
    case (s1AluOp)
      ADD: addCin = 1'b0;
      ADC: addCin = s1CarryIn;
      SUB: begin
        addB   = ~s1ShiftedB;
        addCin = 1'b1;
      end
      SBC: begin
        addB   = ~s1ShiftedB;
        addCin = s1CarryIn;
      end
      RSB: begin
        addA   = s1ShiftedB;
        addB   = ~s1OperandA;
        addCin = 1'b1;
      end
      default: isArith = 1'b0;
    endcase
  end

  assign addSum = {1'b0, addA} + {1'b0, addB} + {{DataWidth{1'b0}}, addCin};

  always_comb begin
    case (s1AluOp)
      AND:     aluNext = s1OperandA & s1ShiftedB;
      EOR:     aluNext = s1OperandA ^ s1ShiftedB;
      ORR:     aluNext = s1OperandA | s1ShiftedB;
      BIC:     aluNext = s1OperandA & ~s1ShiftedB;
      MVN:     aluNext = ~s1ShiftedB;
      default: aluNext = isArith ? addSum[DataWidth-1:0] : s1ShiftedB;
    endcase

    flagsNext[FlagN] = aluNext[DataWidth-1];
    flagsNext[FlagZ] = (aluNext == '0);
    if (isArith) begin
      flagsNext[FlagC] = addSum[DataWidth];
      // Same-sign inputs with a result of the other sign
      flagsNext[FlagV] = (addA[DataWidth-1] == addB[DataWidth-1]) &&
                         (addSum[DataWidth-1] != addA[DataWidth-1]);
    end else begin
      flagsNext[FlagC] = s1ShiftCarry;
      flagsNext[FlagV] = s1OverflowIn;
    end
  end

  always_ff @(posedge clk) begin
    if (s1Valid) begin
      aluResult <= aluNext;
      aluFlags  <= flagsNext;
    end
  end

endmodule

// File: rtl/multiplyUnit.sv
module multiplyUnit #(
  parameter int DataWidth = 32
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 opValid,
  input  logic                 accumulate,
  input  logic [DataWidth-1:0] operandA,
  input  logic [DataWidth-1:0] operandB,
  input  logic [DataWidth-1:0] operandC,
  output logic [DataWidth-1:0] multResult,
  output logic [1:0]           multNZ
);

  localparam int HalfWidth = DataWidth / 2;

  // Partial products for the low and high halves of operand B
  logic [DataWidth-1:0] partLow;
  logic [HalfWidth-1:0] partHigh;

  // Stage 1 registers
  logic                 s1Valid;
  logic [DataWidth-1:0] s1PartLow;
  logic [HalfWidth-1:0] s1PartHigh;
  logic [DataWidth-1:0] s1OperandC;
  logic                 s1Accumulate;

  logic [DataWidth-1:0] product;
  logic [DataWidth-1:0] productNext;

  // ====================
  // Stage 1
  // ====================

  assign partLow = operandA * operandB[HalfWidth-1:0];
  // Only the low half survives the shift into the truncated product
  assign partHigh = operandA[HalfWidth-1:0] * operandB[DataWidth-1:HalfWidth];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= opValid;
    end
  end

  always_ff @(posedge clk) begin
    if (opValid) begin
      s1PartLow    <= partLow;
      s1PartHigh   <= partHigh;
      s1OperandC   <= operandC;
      s1Accumulate <= accumulate;
    end
  end

  // ====================
  // Stage 2
  // ====================

  assign product     = s1PartLow + {s1PartHigh, {HalfWidth{1'b0}}};
  assign productNext = s1Accumulate ? product + s1OperandC : product;

  always_ff @(posedge clk) begin
    if (s1Valid) begin
      multResult <= productNext;
      // N in bit 1, Z in bit 0
      multNZ     <= {productNext[DataWidth-1], productNext == '0};
    end
  end

endmodule

// File: rtl/resultMerge.sv
module resultMerge import armExecPkg::*; #(
  parameter int DataWidth = 32
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   opValid,
  input  logic                   setFlags,
  input  unitSel_e               unitSel,
  input  logic [RegTagWidth-1:0] destReg,
  input  logic [3:0]             flagsIn,
  input  logic [DataWidth-1:0]   aluResult,
  input  logic [DataWidth-1:0]   multResult,
  input  logic [3:0]             aluFlags,
  input  logic [1:0]             multNZ,
  output logic                   resultValid,
  output logic                   flagsWrite,
  output logic [DataWidth-1:0]   result,
  output logic [RegTagWidth-1:0] resultDest,
  output logic [3:0]             flagsOut
);

  // Tag pipeline
  logic                   s1Valid;
  logic                   s1SetFlags;
  unitSel_e               s1UnitSel;
  logic [RegTagWidth-1:0] s1DestReg;
  logic [3:0]             s1FlagsIn;
  logic                   s2Valid;
  logic                   s2SetFlags;
  unitSel_e               s2UnitSel;
  logic [RegTagWidth-1:0] s2DestReg;
  logic [3:0]             s2FlagsIn;

  logic [DataWidth-1:0] resultSel;
  logic [3:0]           flagsSel;

  // ====================
  // Tag pipeline
  // ====================

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s1Valid <= 1'b0;
      s2Valid <= 1'b0;
    end else begin
      s1Valid <= opValid;
      s2Valid <= s1Valid;
    end
  end

  always_ff @(posedge clk) begin
    if (opValid) begin
      s1SetFlags <= setFlags;
      s1UnitSel  <= unitSel;
      s1DestReg  <= destReg;
      s1FlagsIn  <= flagsIn;
    end
    if (s1Valid) begin
      s2SetFlags <= s1SetFlags;
      s2UnitSel  <= s1UnitSel;
      s2DestReg  <= s1DestReg;
      s2FlagsIn  <= s1FlagsIn;
    end
  end

  // ====================
  // Select and output
  // ====================

  // Multiply keeps C and V from its own incoming flags
  always_comb begin
    if (s2UnitSel == UNIT_MULT) begin
      resultSel        = multResult;
      flagsSel[FlagN]  = multNZ[1];
      flagsSel[FlagZ]  = multNZ[0];
      flagsSel[FlagC]  = s2FlagsIn[FlagC];
      flagsSel[FlagV]  = s2FlagsIn[FlagV];
    end else begin
      resultSel = aluResult;
      flagsSel  = aluFlags;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      flagsWrite  <= 1'b0;
      result      <= '0;
      resultDest  <= '0;
      flagsOut    <= '0;
    end else begin
      resultValid <= s2Valid;
      flagsWrite  <= s2Valid & s2SetFlags;
      if (s2Valid) begin
        result     <= resultSel;
        resultDest <= s2DestReg;
        flagsOut   <= flagsSel;
      end
    end
  end

endmodule

// File: rtl/execUnit.sv
module execUnit import armExecPkg::*; #(
  parameter int DataWidth = 32
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         opValid,
  input  unitSel_e                     unitSel,
  input  aluOp_e                       aluOp,
  input  shiftOp_e                     shiftOp,
  input  logic [$clog2(DataWidth)-1:0] shiftAmount,
  input  logic [DataWidth-1:0]         operandA,
  input  logic [DataWidth-1:0]         operandB,
  input  logic [DataWidth-1:0]         operandC,
  input  logic                         accumulate,
  input  logic                         setFlags,
  input  logic [RegTagWidth-1:0]       destReg,
  input  logic [3:0]                   flagsIn,
  output logic                         resultValid,
  output logic [DataWidth-1:0]         result,
  output logic [RegTagWidth-1:0]       resultDest,
  output logic [3:0]                   flagsOut,
  output logic                         flagsWrite
);

  // Unit results into the merge stage
  logic [DataWidth-1:0] aluResult;
  logic [3:0]           aluFlags;
  logic [DataWidth-1:0] multResult;
  logic [1:0]           multNZ;

  // ====================
  // Execution units
  // ====================

  // Both units compute every operation
  shiftAlu #(.DataWidth(DataWidth)) uShiftAlu (
    .clk         (clk),
    .rstN        (rstN),
    .opValid     (opValid),
    .aluOp       (aluOp),
    .shiftOp     (shiftOp),
    .shiftAmount (shiftAmount),
    .operandA    (operandA),
    .operandB    (operandB),
    .flagsIn     (flagsIn),
    .aluResult   (aluResult),
    .aluFlags    (aluFlags)
  );

  multiplyUnit #(.DataWidth(DataWidth)) uMultiply (
    .clk        (clk),
    .rstN       (rstN),
    .opValid    (opValid),
    .accumulate (accumulate),
    .operandA   (operandA),
    .operandB   (operandB),
    .operandC   (operandC),
    .multResult (multResult),
    .multNZ     (multNZ)
  );

  // ====================
  // Merge and output
  // ====================

  resultMerge #(.DataWidth(DataWidth)) uMerge (
    .clk         (clk),
    .rstN        (rstN),
    .opValid     (opValid),
    .setFlags    (setFlags),
    .unitSel     (unitSel),
    .destReg     (destReg),
    .flagsIn     (flagsIn),
    .aluResult   (aluResult),
    .multResult  (multResult),
    .aluFlags    (aluFlags),
    .multNZ      (multNZ),
    .resultValid (resultValid),
    .flagsWrite  (flagsWrite),
    .result      (result),
    .resultDest  (resultDest),
    .flagsOut    (flagsOut)
  );

endmodule

// File: dv/clockGen.sv
module clockGen (
  output logic clk,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held low for the first 16 rising edges
  initial begin
    rstN = 1'b0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

// File: dv/execUnit_assertions.sv
module execUnit_assertions import armExecPkg::*; #(
  parameter int DataWidth = 32
) (
  input logic                 clk,
  input logic                 rstN,
  input logic                 opValid,
  input logic                 resultValid,
  input logic                 flagsWrite,
  input logic [DataWidth-1:0] result
);
  timeunit 1ns;
  timeprecision 1ps;

  // Strobe is sampled ExecLatency edges after the edge that samples the operation
  assert property (@(posedge clk) disable iff (!rstN)
    opValid |-> ##ExecLatency resultValid)
    else $error("resultValid missing after an accepted operation");

  assert property (@(posedge clk) disable iff (!rstN)
    resultValid |-> $past(opValid, ExecLatency))
    else $error("resultValid without a matching operation");

  assert property (@(posedge clk) disable iff (!rstN) flagsWrite |-> resultValid)
    else $error("flagsWrite high while resultValid is low");

  assert property (@(posedge clk) disable iff (!rstN) resultValid |-> !$isunknown(result))
    else $error("result has unknown bits while resultValid is high");

endmodule

bind execUnit execUnit_assertions #(.DataWidth(DataWidth)) uAssertions (.*);

// File: dv/execUnitTb.sv
module execUnitTb import armExecPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TableLen = 17;
  localparam int RandomOps = 200;
  localparam int TimeoutCycles = (TableLen + RandomOps + ExecLatency) * 2 + 100;

  typedef struct packed {
    unitSel_e    unit;
    aluOp_e      aluOp;
    shiftOp_e    shiftOp;
    logic [4:0]  amount;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic        acc;
    logic        setFlags;
    logic [3:0]  dest;
    logic [3:0]  flagsIn;
    logic [31:0] expResult;
    logic [3:0]  expFlags;
  } opRow_t;

  typedef struct packed {
    logic [31:0] result;
    logic [3:0]  dest;
    logic [3:0]  flags;
    logic        flagsWrite;
    int          dueCycle;
  } expEntry_t;

  logic        clk;
  logic        rstN;
  logic        opValid;
  unitSel_e    unitSel;
  aluOp_e      aluOp;
  shiftOp_e    shiftOp;
  logic [4:0]  shiftAmount;
  logic [31:0] operandA;
  logic [31:0] operandB;
  logic [31:0] operandC;
  logic        accumulate;
  logic        setFlags;
  logic [3:0]  destReg;
  logic [3:0]  flagsIn;
  logic        resultValid;
  logic [31:0] result;
  logic [3:0]  resultDest;
  logic [3:0]  flagsOut;
  logic        flagsWrite;

  expEntry_t   expQ[$];
  int          cycleCount = 0;
  int          passCount = 0;
  int          failCount = 0;
  int          testErrors = 0;
  logic [63:0] lcgState = 64'd72;
  aluOp_e      aluOps[11] = '{AND, EOR, SUB, RSB, ADD, ADC, SBC, ORR, BIC, MOV, MVN};

  // unit, op, shift, amount, A, B, C, acc, setFlags, dest, flagsIn, result, NZCV
  opRow_t dirTable[TableLen] = '{
    '{UNIT_ALU, ADD, LSL, 5'd0, 32'h7fffffff, 32'h1, 32'h0, 1'b0, 1'b1, 4'h1, 4'h0,
      32'h80000000, 4'h9},
    '{UNIT_ALU, ADD, LSL, 5'd0, 32'hffffffff, 32'h1, 32'h0, 1'b0, 1'b1, 4'h2, 4'h0, 32'h0, 4'h6},
    '{UNIT_ALU, SUB, LSL, 5'd0, 32'h5, 32'h7, 32'h0, 1'b0, 1'b1, 4'h3, 4'h0, 32'hfffffffe, 4'h8},
    '{UNIT_ALU, SUB, LSL, 5'd0, 32'h80000000, 32'h1, 32'h0, 1'b0, 1'b1, 4'h4, 4'h0,
      32'h7fffffff, 4'h3},
    '{UNIT_ALU, RSB, LSL, 5'd0, 32'h3, 32'ha, 32'h0, 1'b0, 1'b1, 4'h5, 4'h0, 32'h7, 4'h2},
    '{UNIT_ALU, ADC, LSL, 5'd0, 32'h1, 32'h2, 32'h0, 1'b0, 1'b0, 4'h6, 4'h2, 32'h4, 4'h0},
    '{UNIT_ALU, SBC, LSL, 5'd0, 32'h5, 32'h5, 32'h0, 1'b0, 1'b1, 4'h7, 4'h0, 32'hffffffff, 4'h8},
    '{UNIT_ALU, SBC, LSL, 5'd0, 32'h5, 32'h5, 32'h0, 1'b0, 1'b1, 4'h8, 4'h2, 32'h0, 4'h6},
    '{UNIT_ALU, MOV, LSL, 5'd1, 32'h0, 32'h80000001, 32'h0, 1'b0, 1'b1, 4'h9, 4'h0, 32'h2, 4'h2},
    '{UNIT_ALU, MOV, LSR, 5'd0, 32'h0, 32'h80000000, 32'h0, 1'b0, 1'b1, 4'ha, 4'h3,
      32'h80000000, 4'hb},
    '{UNIT_ALU, AND, LSR, 5'd31, 32'hffffffff, 32'hc0000000, 32'h0, 1'b0, 1'b1, 4'hb, 4'h0,
      32'h1, 4'h2},
    '{UNIT_ALU, EOR, ASR, 5'd31, 32'h0000ffff, 32'h80000000, 32'h0, 1'b0, 1'b1, 4'hc, 4'h0,
      32'hffff0000, 4'h8},
    '{UNIT_ALU, ORR, ROR, 5'd1, 32'h0, 32'h1, 32'h0, 1'b0, 1'b1, 4'hd, 4'h0, 32'h80000000, 4'ha},
    '{UNIT_ALU, BIC, ROR, 5'd31, 32'hffffffff, 32'h1, 32'h0, 1'b0, 1'b1, 4'he, 4'h1,
      32'hfffffffd, 4'h9},
    '{UNIT_ALU, MVN, ASR, 5'd1, 32'h0, 32'h80000001, 32'h0, 1'b0, 1'b0, 4'hf, 4'h0,
      32'h3fffffff, 4'h2},
    '{UNIT_MULT, AND, LSL, 5'd0, 32'h00010003, 32'h00020005, 32'h0, 1'b0, 1'b1, 4'h0, 4'h3,
      32'h000b000f, 4'h3},
    '{UNIT_MULT, AND, LSL, 5'd0, 32'hffffffff, 32'h2, 32'h2, 1'b1, 1'b1, 4'h3, 4'h0, 32'h0, 4'h4}
  };

  clockGen uClock (
    .clk  (clk),
    .rstN (rstN)
  );

  execUnit #(.DataWidth(32)) dut (.*);

  // ====================
  // Reference model
  // ====================

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcgState[63:32];
  endfunction

  // Shifts one bit at a time and returns {carry, value}
  function automatic logic [32:0] shiftRef(input shiftOp_e op, input logic [4:0] amount,
                                           input logic [31:0] b, input logic carryIn);
    logic [31:0] v;
    logic        c;
    v = b;
    c = carryIn;
    for (int i = 0; i < amount; i++) begin
      c = (op == LSL) ? v[31] : v[0];
      case (op)
        LSL: v = v << 1;
        LSR: v = v >> 1;
        ASR: v = {v[31], v[31:1]};
        ROR: v = {v[0], v[31:1]};
      endcase
    end
    return {c, v};
  endfunction

  // Returns {NZCV, result}
  function automatic logic [35:0] aluRef(input aluOp_e op, input logic [31:0] a,
                                         input logic [31:0] b, input logic [3:0] fin,
                                         input logic shC);
    longint      ures;
    longint      sres;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    logic [3:0]  f;
    int          k;
    bit          isSub;
    x = a;
    y = b;
    k = 0;
    isSub = 1'b0;
    f = fin;
    f[FlagC] = shC;
    case (op)
      ADC: k = fin[FlagC];
      SUB: isSub = 1'b1;
      SBC: begin
        // Borrow is the inverse of the incoming carry
        isSub = 1'b1;
        k = !fin[FlagC];
      end
      RSB: begin
        isSub = 1'b1;
        x = b;
        y = a;
      end
      default: ;
    endcase
    if (isSub) begin
      ures = longint'(x) - longint'(y) - k;
      sres = longint'($signed(x)) - longint'($signed(y)) - k;
    end else begin
      ures = longint'(x) + longint'(y) + k;
      sres = longint'($signed(x)) + longint'($signed(y)) + k;
    end
    case (op)
      AND: r = a & b;
      EOR: r = a ^ b;
      ORR: r = a | b;
      BIC: r = a & ~b;
      MOV: r = b;
      MVN: r = ~b;
      default: begin
        r = ures[31:0];
        f[FlagC] = isSub ? (ures >= 0) : ures[32];
        // Overflow when the true signed value does not fit in 32 bits
        f[FlagV] = (sres != longint'($signed(r)));
      end
    endcase
    f[FlagN] = r[31];
    f[FlagZ] = (r == 32'h0);
    return {f, r};
  endfunction

  function automatic opRow_t withExpected(input opRow_t op);
    logic [32:0] shifted;
    logic [63:0] product;
    opRow_t      row;
    row = op;
    if (op.unit == UNIT_MULT) begin
      product = {32'h0, op.a} * {32'h0, op.b};
      row.expResult = product[31:0] + (op.acc ? op.c : 32'h0);
      row.expFlags = op.flagsIn;
      row.expFlags[FlagN] = row.expResult[31];
      row.expFlags[FlagZ] = (row.expResult == 32'h0);
    end else begin
      shifted = shiftRef(op.shiftOp, op.amount, op.b, op.flagsIn[FlagC]);
      {row.expFlags, row.expResult} = aluRef(op.aluOp, op.a, shifted[31:0], op.flagsIn,
                                             shifted[32]);
    end
    return row;
  endfunction

  function automatic opRow_t randomOp();
    logic [31:0] r;
    logic [31:0] s;
    opRow_t      op;
    r = nextRand();
    s = nextRand();
    op.unit = (r[1:0] == 2'b00) ? UNIT_MULT : UNIT_ALU;
    op.aluOp = aluOps[r[31:16] % 11];
    op.shiftOp = shiftOp_e'(r[3:2]);
    // Edge amounts show up often
    case (r[5:4])
      2'd0: op.amount = 5'd0;
      2'd1: op.amount = 5'd1;
      2'd2: op.amount = 5'd31;
      default: op.amount = s[4:0];
    endcase
    op.acc = r[6];
    op.setFlags = r[7];
    op.dest = r[11:8];
    op.flagsIn = r[15:12];
    op.a = nextRand();
    op.b = nextRand();
    op.c = nextRand();
    return withExpected(op);
  endfunction

  // ====================
  // Driving and checking
  // ====================

  task automatic issueOp(input opRow_t op);
    expEntry_t e;
    @(posedge clk);
    opValid     <= 1'b1;
    unitSel     <= op.unit;
    aluOp       <= op.aluOp;
    shiftOp     <= op.shiftOp;
    shiftAmount <= op.amount;
    operandA    <= op.a;
    operandB    <= op.b;
    operandC    <= op.c;
    accumulate  <= op.acc;
    setFlags    <= op.setFlags;
    destReg     <= op.dest;
    flagsIn     <= op.flagsIn;
    e.result = op.expResult;
    e.dest = op.dest;
    e.flags = op.expFlags;
    e.flagsWrite = op.setFlags;
    // Registered ExecLatency edges after this one and seen at the edge after that
    e.dueCycle = cycleCount + ExecLatency + 1;
    expQ.push_back(e);
  endtask

  task automatic idleCycle();
    @(posedge clk);
    opValid <= 1'b0;
  endtask

  task automatic drain();
    idleCycle();
    while (expQ.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  task automatic recordCheck(input bit ok);
    if (ok) begin
      passCount++;
    end else begin
      failCount++;
      testErrors++;
    end
  endtask

  task automatic reportTest(input string name);
    $display("test %s done with %0d errors", name, testErrors);
    testErrors = 0;
  endtask

  task automatic checkIdle();
    bit ok;
    ok = 1'b1;
    if (resultValid !== 1'b0) begin
      $display("error resultValid: expected 0, actual %h", resultValid);
      ok = 1'b0;
    end
    if (flagsWrite !== 1'b0) begin
      $display("error flagsWrite: expected 0, actual %h", flagsWrite);
      ok = 1'b0;
    end
    if (flagsOut !== 4'h0) begin
      $display("error flagsOut: expected 0, actual %h", flagsOut);
      ok = 1'b0;
    end
    recordCheck(ok);
  endtask

  task automatic checkResult();
    expEntry_t e;
    bit        ok;
    ok = 1'b1;
    if (expQ.size() == 0) begin
      $display("result strobe at cycle %0d with no operation outstanding", cycleCount);
      ok = 1'b0;
    end else begin
      e = expQ.pop_front();
      if (cycleCount != e.dueCycle) begin
        $display("result arrived at cycle %0d instead of cycle %0d", cycleCount, e.dueCycle);
        ok = 1'b0;
      end
      if (result !== e.result) begin
        $display("error result: expected %h, actual %h", e.result, result);
        ok = 1'b0;
      end
      if (resultDest !== e.dest) begin
        $display("error resultDest: expected %h, actual %h", e.dest, resultDest);
        ok = 1'b0;
      end
      if (flagsOut !== e.flags) begin
        $display("error flagsOut: expected %h, actual %h", e.flags, flagsOut);
        ok = 1'b0;
      end
      if (flagsWrite !== e.flagsWrite) begin
        $display("error flagsWrite: expected %h, actual %h", e.flagsWrite, flagsWrite);
        ok = 1'b0;
      end
    end
    recordCheck(ok);
  endtask

  // Outputs seen here are the values from the previous edge
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("timeout after %0d cycles with %0d results outstanding", cycleCount,
               expQ.size());
      $display("sim failed");
      $finish;
    end else begin
      if (flagsWrite === 1'b1 && resultValid !== 1'b1) begin
        $display("flagsWrite raised without resultValid at cycle %0d", cycleCount);
        recordCheck(1'b0);
      end
      if (resultValid === 1'b1) checkResult();
    end
  end

  initial begin
    opRow_t      op;
    logic [31:0] gapRand;
    opValid = 1'b0;
    unitSel = UNIT_ALU;
    aluOp = AND;
    shiftOp = LSL;
    shiftAmount = '0;
    operandA = '0;
    operandB = '0;
    operandC = '0;
    accumulate = 1'b0;
    setFlags = 1'b0;
    destReg = '0;
    flagsIn = '0;

    // Outputs stay clear through reset and just after it
    repeat (18) begin
      @(posedge clk);
      if (cycleCount > 0) checkIdle();
    end
    reportTest("reset");

    foreach (dirTable[i]) issueOp(dirTable[i]);
    drain();
    reportTest("directed table");

    for (int i = 0; i < RandomOps; i++) begin
      op = randomOp();
      gapRand = nextRand();
      if (gapRand[2:0] == 3'd0) idleCycle();
      issueOp(op);
    end
    drain();
    reportTest("random stream");

    $display("checks passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: execUnit.f
rtl/armExecPkg.sv
rtl/shiftAlu.sv
rtl/multiplyUnit.sv
rtl/resultMerge.sv
rtl/execUnit.sv
dv/clockGen.sv
dv/execUnit_assertions.sv
dv/execUnitTb.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - rtl/armExecPkg.sv
      - rtl/shiftAlu.sv
      - rtl/multiplyUnit.sv
      - rtl/resultMerge.sv
      - rtl/execUnit.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/execUnit_assertions.sv
      - dv/execUnitTb.sv
